// File: verilog/clock_ctrl_settings.svh
`ifndef CLOCK_CTRL_SETTINGS_SVH
`define CLOCK_CTRL_SETTINGS_SVH

// Comparator phase table entries, one per 5-bit request
`define CMP_TABLE_SIZE 32
// Fine steps in one 25 ns period (1/56 of VCO period, VCO at 24 x 40 MHz)
`define CMP_STEPS_PER_CYCLE 1344
// Wait after psdone, covers the tracker compare pipeline
`define CMP_SETTLE_CYCLES 3

// CLK40 cycles per microsecond tick
`define US_TICK_DIV 40
// Data stream resync holdoff in microseconds
`define DSR_HOLDOFF_TICKS 100
// Sampling MMCM reset stretch length
`define SAMP_RST_PIPE_LEN 8

`endif

// File: verilog/cmp_phase_pkg.sv
package cmp_phase_pkg;

	// ----------------------------------------
	// Comparator clock phase values
	// ----------------------------------------

	// Fine-step phase, 0 to 1344
	typedef logic [10:0] cmp_phase_t;

	// Coarse phase request, 32 steps per cycle
	typedef logic [4:0] cmp_phase_idx_t;

	// ----------------------------------------
	// Dynamic phase shift sequencing
	// ----------------------------------------
	typedef enum logic [2:0]
	{
		st_idle,
		st_step,
		st_wait_done,
		st_settle
	} phs_shift_state_t;

	// Observation bundle for the shift port
	typedef struct packed
	{
		logic             busy;
		logic             psen;
		logic             psdone;
		logic             mmcm_rst;
		phs_shift_state_t state;
	} cmp_phs_status_t;

endpackage

// File: verilog/resync_pkg.sv
`include "clock_ctrl_settings.svh"

package resync_pkg;

	// Holdoff length in microsecond ticks
	typedef logic [7:0] holdoff_cnt_t;

	// CLK40 to 1 us divider, counts 0 to 39
	typedef logic [5:0] us_div_t;

	// Capture history for the sampling MMCM reset
	typedef logic [`SAMP_RST_PIPE_LEN-1:0] samp_rst_pipe_t;

	// ----------------------------------------
	// Sampling clock controls
	// ----------------------------------------
	typedef struct packed
	{
		logic cap_phase;
		logic samp_mmcm_rst;
		logic c20_phase_sel;
		logic samp_in_sel;
		logic dsr_resync;
	} samp_ctrl_t;

endpackage

// File: verilog/cmp_phase_cfg.sv
`timescale 1ns/100ps

`include "clock_ctrl_settings.svh"

module cmp_phase_cfg
	import cmp_phase_pkg::*;
(
	input  logic           CLK40,
	input  cmp_phase_idx_t cmp_clk_phase,
	output cmp_phase_t     target
);

	// ----------------------------------------
	// Phase lookup table
	// ----------------------------------------

	// Spreads 32 requests over one full period of fine steps
	// Last entry lands exactly on a whole period
	cmp_phase_t phase_table [`CMP_TABLE_SIZE];

	// Rounded i * steps / 31 in integer arithmetic
	function automatic cmp_phase_t table_entry(input int idx);
		int num;
		int den;
		num = 2 * idx * `CMP_STEPS_PER_CYCLE + (`CMP_TABLE_SIZE - 1);
		den = 2 * (`CMP_TABLE_SIZE - 1);
		return cmp_phase_t'(num / den);
	endfunction

	generate
		for (genvar i = 0; i < `CMP_TABLE_SIZE; i++)
		begin : g_table
			// Fixed at elaboration
			localparam cmp_phase_t ENTRY = table_entry(i);

			assign phase_table[i] = ENTRY;
		end
	endgenerate

	// ----------------------------------------
	// Registered target
	// ----------------------------------------

	// One cycle from request to target
	always_ff @(posedge CLK40)
	begin
		target <= phase_table[cmp_clk_phase];
	end

endmodule

// File: verilog/cmp_phase_tracker.sv
`timescale 1ns/100ps

module cmp_phase_tracker
	import cmp_phase_pkg::*;
(
	input  logic       CLK40,
	input  logic       mmcm_rst,
	input  cmp_phase_t target,
	input  logic       psen,
	output logic       psincdec,
	output logic       phs_change,
	output cmp_phase_t cur_phase
);

	// Target and current phase differ
	logic phs_mismatch;

	// ----------------------------------------
	// Presumed MMCM phase
	// ----------------------------------------

	// MMCM comes out of reset at zero phase offset
	// Each psen moves it one fine step
	always_ff @(posedge CLK40 or posedge mmcm_rst)
	begin
		if (mmcm_rst)
			cur_phase <= '0;
		else if (psen)
		begin
			if (psincdec)
				cur_phase <= cur_phase + cmp_phase_t'(1);
			else
				cur_phase <= cur_phase - cmp_phase_t'(1);
		end
	end

	// ----------------------------------------
	// Direction and change request
	// ----------------------------------------

	// Step up when target is ahead
	// Change flag lags mismatch by a cycle so a finished step settles first
	always_ff @(posedge CLK40 or posedge mmcm_rst)
	begin
		if (mmcm_rst)
		begin
			psincdec     <= 1'b0;
			phs_mismatch <= 1'b0;
			phs_change   <= 1'b0;
		end
		else
		begin
			psincdec     <= (target > cur_phase);
			phs_mismatch <= (target != cur_phase);
			phs_change   <= phs_mismatch;
		end
	end

endmodule

// File: verilog/dyn_phase_shift_fsm.sv
`timescale 1ns/100ps

`include "clock_ctrl_settings.svh"

module dyn_phase_shift_fsm
	import cmp_phase_pkg::*;
(
	input  logic             CLK40,
	input  logic             mmcm_rst,
	input  logic             locked,
	input  logic             phs_change,
	input  logic             psdone,
	output logic             psen,
	output logic             busy,
	output phs_shift_state_t state
);

	localparam int SETTLE_W = $clog2(`CMP_SETTLE_CYCLES + 1);
	localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(`CMP_SETTLE_CYCLES - 1);

	phs_shift_state_t        next_state;
	logic [SETTLE_W-1:0]     settle_cnt;

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			// Only step a locked MMCM
			st_idle:
				if (locked && phs_change)
					next_state = st_step;
			// Single psen cycle
			st_step:
				next_state = st_wait_done;
			// Step latency varies, wait for the answer
			st_wait_done:
				if (psdone)
					next_state = st_settle;
			// Let tracker flag catch up, avoids an extra step
			st_settle:
				if (settle_cnt == SETTLE_LAST)
					next_state = st_idle;
			default:
				next_state = st_idle;
		endcase
	end

	// ----------------------------------------
	// State and settle counter
	// ----------------------------------------
	always_ff @(posedge CLK40 or posedge mmcm_rst)
	begin
		if (mmcm_rst)
		begin
			state      <= st_idle;
			settle_cnt <= '0;
		end
		else
		begin
			state <= next_state;
			// Counts only while settling
			if (state == st_settle)
				settle_cnt <= settle_cnt + 1'b1;
			else
				settle_cnt <= '0;
		end
	end

	// Decoded outputs
	assign psen = (state == st_step);
	assign busy = (state != st_idle);

endmodule

// File: verilog/resync_phase_ctrl.sv
`timescale 1ns/100ps

`include "clock_ctrl_settings.svh"

module resync_phase_ctrl
	import resync_pkg::*;
(
	input  logic       CLK40,
	input  logic       RST,
	input  logic       resync,
	input  logic [2:0] samp_clk_phase,
	input  logic       samp_clk_phs_chng,
	output logic       cap_phase,
	output logic       samp_mmcm_rst,
	output logic       c20_phase_sel,
	output logic       samp_in_sel
);

	logic           rst_d1;
	logic           rst_d2;
	logic           trl_edg_rst;
	logic           resync_d1;
	logic           lead_edg_resync;
	logic           lead_edg_resync_d1;
	logic           clk20_phase;
	samp_rst_pipe_t rst_mmcm_pipe;

	// ----------------------------------------
	// Edge detection
	// ----------------------------------------

	// Reset history held high during reset
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			rst_d1 <= 1'b1;
			rst_d2 <= 1'b1;
		end
		else
		begin
			rst_d1 <= 1'b0;
			rst_d2 <= rst_d1;
		end
	end

	// Two cycles wide
	assign trl_edg_rst = ~RST & rst_d2;
	// One cycle wide
	assign lead_edg_resync = resync & ~resync_d1;

	// ----------------------------------------
	// Capture pulse and MMCM reset stretch
	// ----------------------------------------
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			resync_d1          <= 1'b0;
			lead_edg_resync_d1 <= 1'b0;
			cap_phase          <= 1'b0;
			rst_mmcm_pipe      <= '0;
			clk20_phase        <= 1'b0;
			c20_phase_sel      <= 1'b0;
		end
		else
		begin
			resync_d1          <= resync;
			lead_edg_resync_d1 <= lead_edg_resync;
			// Resync edge gives a two cycle capture
			cap_phase <= lead_edg_resync | lead_edg_resync_d1 | trl_edg_rst | samp_clk_phs_chng;
			rst_mmcm_pipe <= {rst_mmcm_pipe[`SAMP_RST_PIPE_LEN-2:0], cap_phase};
			// Tracks the 20 MHz divider phase, aligned by resync
			clk20_phase <= lead_edg_resync ? 1'b0 : ~clk20_phase;
			// Half-phase frozen at each capture
			if (cap_phase)
				c20_phase_sel <= clk20_phase;
		end
	end

	// Held in reset while any recent capture
	assign samp_mmcm_rst = |rst_mmcm_pipe;

	// Sampling MMCM input clock select, 20 MHz or its inverse
	assign samp_in_sel = samp_clk_phase[2] ^ c20_phase_sel;

endmodule

// File: verilog/dsr_holdoff.sv
`timescale 1ns/100ps

`include "clock_ctrl_settings.svh"

module dsr_holdoff
	import resync_pkg::*;
(
	input  logic CLK40,
	input  logic RST,
	input  logic cap_phase,
	output logic dsr_resync
);

	us_div_t      us_div;
	logic         us_tick;
	holdoff_cnt_t ho_cnt;
	logic         clr_ho;

	// Last divider count gives the 1 us tick
	assign us_tick = (us_div == us_div_t'(`US_TICK_DIV - 1));
	// 100 us elapsed
	assign clr_ho = dsr_resync && (ho_cnt == holdoff_cnt_t'(`DSR_HOLDOFF_TICKS));

	// ----------------------------------------
	// Holdoff flag
	// ----------------------------------------

	// Capture while running does not restart
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
			dsr_resync <= 1'b0;
		else if (clr_ho)
			dsr_resync <= 1'b0;
		else if (cap_phase)
			dsr_resync <= 1'b1;
	end

	// ----------------------------------------
	// Tick divider and timer
	// ----------------------------------------

	// Both cleared while idle
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			us_div <= '0;
			ho_cnt <= '0;
		end
		else if (!dsr_resync)
		begin
			us_div <= '0;
			ho_cnt <= '0;
		end
		else if (us_tick)
		begin
			us_div <= '0;
			ho_cnt <= ho_cnt + 1'b1;
		end
		else
			us_div <= us_div + 1'b1;
	end

endmodule

// File: verilog/clock_phase_ctrl.sv
`timescale 1ns/100ps

module clock_phase_ctrl
	import cmp_phase_pkg::*;
	import resync_pkg::*;
(
	input  logic            CLK40,
	input  logic            RST,
	// Comparator clock side
	input  logic            cmp_phs_jtag_rst,
	input  cmp_phase_idx_t  cmp_clk_phase,
	input  logic            cmp_psdone,
	input  logic            cmp_locked,
	output logic            cmp_psen,
	output logic            cmp_psincdec,
	output logic            cmp_mmcm_rst,
	output logic            cmp_phs_change,
	output cmp_phase_t      cmp_phase,
	output cmp_phs_status_t cmp_phs_status,
	// Sampling clock side
	input  logic            resync,
	input  logic [2:0]      samp_clk_phase,
	input  logic            samp_clk_phs_chng,
	output samp_ctrl_t      samp_ctrl
);

	logic             cmp_busy;
	phs_shift_state_t cmp_state;
	logic             cap_phase;
	logic             samp_mmcm_rst;
	logic             c20_phase_sel;
	logic             samp_in_sel;
	logic             dsr_resync;

	// MMCM and its phase tracking restart together
	assign cmp_mmcm_rst = RST | cmp_phs_jtag_rst;

	// ----------------------------------------
	// Comparator clock phase
	// ----------------------------------------
	cmp_phase_cfg u_cmp_phase_cfg (
		.CLK40         (CLK40),
		.cmp_clk_phase (cmp_clk_phase),
		.target        (cmp_phase)
	);

	cmp_phase_tracker u_cmp_phase_tracker (
		.CLK40      (CLK40),
		.mmcm_rst   (cmp_mmcm_rst),
		.target     (cmp_phase),
		.psen       (cmp_psen),
		.psincdec   (cmp_psincdec),
		.phs_change (cmp_phs_change),
		.cur_phase  ()
	);

	dyn_phase_shift_fsm u_dyn_phase_shift_fsm (
		.CLK40      (CLK40),
		.mmcm_rst   (cmp_mmcm_rst),
		.locked     (cmp_locked),
		.phs_change (cmp_phs_change),
		.psdone     (cmp_psdone),
		.psen       (cmp_psen),
		.busy       (cmp_busy),
		.state      (cmp_state)
	);

	assign cmp_phs_status = '{busy: cmp_busy, psen: cmp_psen, psdone: cmp_psdone,
		mmcm_rst: cmp_mmcm_rst, state: cmp_state};

	// ----------------------------------------
	// Sampling clock alignment
	// ----------------------------------------
	resync_phase_ctrl u_resync_phase_ctrl (
		.CLK40             (CLK40),
		.RST               (RST),
		.resync            (resync),
		.samp_clk_phase    (samp_clk_phase),
		.samp_clk_phs_chng (samp_clk_phs_chng),
		.cap_phase         (cap_phase),
		.samp_mmcm_rst     (samp_mmcm_rst),
		.c20_phase_sel     (c20_phase_sel),
		.samp_in_sel       (samp_in_sel)
	);

	dsr_holdoff u_dsr_holdoff (
		.CLK40      (CLK40),
		.RST        (RST),
		.cap_phase  (cap_phase),
		.dsr_resync (dsr_resync)
	);

	assign samp_ctrl = '{cap_phase: cap_phase, samp_mmcm_rst: samp_mmcm_rst,
		c20_phase_sel: c20_phase_sel, samp_in_sel: samp_in_sel, dsr_resync: dsr_resync};

endmodule

// File: tests/clock_phase_ctrl_assert.sv
`timescale 1ns/100ps

`include "clock_ctrl_settings.svh"

module clock_phase_ctrl_assert
	import cmp_phase_pkg::*;
	import resync_pkg::*;
(
	input logic            CLK40,
	input logic            RST,
	input logic            cmp_phs_jtag_rst,
	input logic            cmp_mmcm_rst,
	input logic            cmp_psen,
	input logic            cmp_psdone,
	input logic            cmp_locked,
	input logic            cmp_phs_change,
	input cmp_phs_status_t cmp_phs_status,
	input logic            resync,
	input logic [2:0]      samp_clk_phase,
	input logic            samp_clk_phs_chng,
	input samp_ctrl_t      samp_ctrl
);

	// Holdoff window with one cycle of slack
	localparam int HOLDOFF_MIN = `DSR_HOLDOFF_TICKS * `US_TICK_DIV;
	localparam int HOLDOFF_MAX = HOLDOFF_MIN + 1;

	int                            fail_count = 0;
	// psen sent and psdone not yet back
	logic                          step_open;
	// Last cap_phase samples with the newest in bit 0
	logic [`SAMP_RST_PIPE_LEN-1:0] cap_hist;
	// Consecutive dsr_resync high samples
	logic [12:0]                   high_len;

	task automatic count_failure(input string msg);
		$error("%s", msg);
		fail_count++;
	endtask

	always_ff @(posedge CLK40 or posedge cmp_mmcm_rst)
	begin
		if (cmp_mmcm_rst)
			step_open <= 1'b0;
		else if (cmp_psen)
			step_open <= 1'b1;
		else if (cmp_psdone)
			step_open <= 1'b0;
	end

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			cap_hist <= '0;
			high_len <= '0;
		end
		else
		begin
			cap_hist <= {cap_hist[`SAMP_RST_PIPE_LEN-2:0], samp_ctrl.cap_phase};
			high_len <= samp_ctrl.dsr_resync ? high_len + 13'd1 : 13'd0;
		end
	end

	// ----------------------------------------
	// Comparator phase shift port
	// ----------------------------------------
	a_mmcm_rst: assert property (@(posedge CLK40)
		cmp_mmcm_rst == (RST || cmp_phs_jtag_rst))
	else
		count_failure("cmp_mmcm_rst differs from RST or JTAG reset");

	a_status: assert property (@(posedge CLK40)
		(cmp_phs_status.psen == cmp_psen) && (cmp_phs_status.psdone == cmp_psdone)
		&& (cmp_phs_status.mmcm_rst == cmp_mmcm_rst))
	else
		count_failure("cmp_phs_status fields differ from the shift port signals");

	a_psen_pulse: assert property (@(posedge CLK40) disable iff (cmp_mmcm_rst)
		$past(cmp_psen) |-> !cmp_psen)
	else
		count_failure("cmp_psen wider than one cycle");

	a_psen_open: assert property (@(posedge CLK40) disable iff (cmp_mmcm_rst)
		cmp_psen |-> !step_open)
	else
		count_failure("cmp_psen sent before psdone of the previous step");

	a_psen_locked: assert property (@(posedge CLK40) disable iff (cmp_mmcm_rst)
		cmp_psen |-> cmp_locked)
	else
		count_failure("cmp_psen sent while the MMCM was not locked");

	// Held idle through RST and JTAG reset
	a_cmp_reset: assert property (@(posedge CLK40)
		(RST || cmp_phs_jtag_rst) |-> (cmp_phs_status.state == st_idle)
		&& !cmp_phs_status.busy && !cmp_psen && !cmp_phs_change)
	else
		count_failure("comparator side not idle during reset");

	// ----------------------------------------
	// Capture and sampling MMCM reset
	// ----------------------------------------
	a_cap_lead: assert property (@(posedge CLK40) disable iff (RST)
		$past(resync) && !$past(resync, 2) |-> samp_ctrl.cap_phase)
	else
		count_failure("no cap_phase in the first cycle after a resync edge");

	a_cap_lead_d: assert property (@(posedge CLK40) disable iff (RST)
		$past(resync, 2) && !$past(resync, 3) |-> samp_ctrl.cap_phase)
	else
		count_failure("no cap_phase in the second cycle after a resync edge");

	a_cap_rst: assert property (@(posedge CLK40) disable iff (RST)
		$past(RST, 2) && !$past(RST) |-> samp_ctrl.cap_phase)
	else
		count_failure("no cap_phase after the end of RST");

	a_cap_chng: assert property (@(posedge CLK40) disable iff (RST)
		$past(samp_clk_phs_chng) |-> samp_ctrl.cap_phase)
	else
		count_failure("no cap_phase after samp_clk_phs_chng");

	a_samp_rst: assert property (@(posedge CLK40) disable iff (RST)
		samp_ctrl.samp_mmcm_rst == (|cap_hist))
	else
		count_failure("samp_mmcm_rst does not match the last 8 cap_phase samples");

	// ----------------------------------------
	// Sampling select and holdoff
	// ----------------------------------------
	a_in_sel: assert property (@(posedge CLK40)
		samp_ctrl.samp_in_sel == (samp_clk_phase[2] ^ samp_ctrl.c20_phase_sel))
	else
		count_failure("samp_in_sel differs from phase bit 2 xor c20_phase_sel");

	a_c20_latch: assert property (@(posedge CLK40) disable iff (RST)
		samp_ctrl.c20_phase_sel != $past(samp_ctrl.c20_phase_sel) |-> $past(samp_ctrl.cap_phase))
	else
		count_failure("c20_phase_sel changed without a capture");

	a_dsr_rise: assert property (@(posedge CLK40) disable iff (RST)
		$past(samp_ctrl.cap_phase && !samp_ctrl.dsr_resync) |-> samp_ctrl.dsr_resync)
	else
		count_failure("dsr_resync did not rise after cap_phase");

	a_dsr_len: assert property (@(posedge CLK40) disable iff (RST)
		$past(samp_ctrl.dsr_resync) && !samp_ctrl.dsr_resync
		|-> (high_len >= HOLDOFF_MIN) && (high_len <= HOLDOFF_MAX))
	else
		count_failure("dsr_resync holdoff length out of range");

	a_samp_reset: assert property (@(posedge CLK40)
		RST |-> !samp_ctrl.cap_phase && !samp_ctrl.dsr_resync && !samp_ctrl.c20_phase_sel)
	else
		count_failure("sampling controls not cleared during RST");

endmodule

// File: tests/tb_clock_phase_ctrl.sv
`timescale 1ns/100ps

`include "clock_ctrl_settings.svh"

module tb_clock_phase_ctrl
	import cmp_phase_pkg::*;
	import resync_pkg::*;
();

	localparam int CLK_PERIOD  = 40;
	localparam int LOCK_CYCLES = 10;
	// Step is at most 12 cycles of psdone plus FSM overhead
	localparam int WALK_LIMIT  = `CMP_STEPS_PER_CYCLE * 18;
	localparam int NUM_WALKS   = 10;
	localparam int HOLDOFF_CYC = `DSR_HOLDOFF_TICKS * `US_TICK_DIV;
	localparam int RUN_LIMIT   = NUM_WALKS * WALK_LIMIT + 4 * HOLDOFF_CYC + 2000;

	logic            CLK40;
	logic            RST;
	logic            cmp_phs_jtag_rst;
	cmp_phase_idx_t  cmp_clk_phase;
	logic            cmp_psdone;
	logic            cmp_locked;
	logic            cmp_psen;
	logic            cmp_psincdec;
	logic            cmp_mmcm_rst;
	logic            cmp_phs_change;
	cmp_phase_t      cmp_phase;
	cmp_phs_status_t cmp_phs_status;
	logic            resync;
	logic [2:0]      samp_clk_phase;
	logic            samp_clk_phs_chng;
	samp_ctrl_t      samp_ctrl;

	integer          seed = 32'hf254_ae29;
	// Phase the MMCM model believes it has
	cmp_phase_t      model_phase;
	int              done_delay;
	int              lock_wait;
	logic            done_fire;

	clock_phase_ctrl DUT (
		.CLK40             (CLK40),
		.RST               (RST),
		.cmp_phs_jtag_rst  (cmp_phs_jtag_rst),
		.cmp_clk_phase     (cmp_clk_phase),
		.cmp_psdone        (cmp_psdone),
		.cmp_locked        (cmp_locked),
		.cmp_psen          (cmp_psen),
		.cmp_psincdec      (cmp_psincdec),
		.cmp_mmcm_rst      (cmp_mmcm_rst),
		.cmp_phs_change    (cmp_phs_change),
		.cmp_phase         (cmp_phase),
		.cmp_phs_status    (cmp_phs_status),
		.resync            (resync),
		.samp_clk_phase    (samp_clk_phase),
		.samp_clk_phs_chng (samp_clk_phs_chng),
		.samp_ctrl         (samp_ctrl)
	);

	bind clock_phase_ctrl clock_phase_ctrl_assert u_assert (
		.CLK40             (CLK40),
		.RST               (RST),
		.cmp_phs_jtag_rst  (cmp_phs_jtag_rst),
		.cmp_mmcm_rst      (cmp_mmcm_rst),
		.cmp_psen          (cmp_psen),
		.cmp_psdone        (cmp_psdone),
		.cmp_locked        (cmp_locked),
		.cmp_phs_change    (cmp_phs_change),
		.cmp_phs_status    (cmp_phs_status),
		.resync            (resync),
		.samp_clk_phase    (samp_clk_phase),
		.samp_clk_phs_chng (samp_clk_phs_chng),
		.samp_ctrl         (samp_ctrl)
	);

	// ----------------------------------------
	// Failure handling
	// ----------------------------------------
	task automatic stop_with_failure();
		$display("Checks failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_with_failure();
	endtask

	// Table rule of i steps of 1/31 period rounded
	function automatic cmp_phase_t rule_phase(input int idx);
		real exact;
		exact = idx * real'(`CMP_STEPS_PER_CYCLE) / real'(`CMP_TABLE_SIZE - 1);
		return cmp_phase_t'($rtoi(exact + 0.5));
	endfunction

	initial
	begin
		CLK40 = 1'b0;
		forever
			#(CLK_PERIOD / 2) CLK40 = ~CLK40;
	end

	// ----------------------------------------
	// MMCM phase shift and lock model
	// ----------------------------------------

	// Samples 1 ns after the edge and drives 2 ns after
	initial
	begin
		cmp_psdone  = 1'b0;
		cmp_locked  = 1'b0;
		model_phase = '0;
		done_delay  = 0;
		lock_wait   = LOCK_CYCLES;
		forever
		begin
			@(posedge CLK40);
			#1;
			done_fire = 1'b0;
			if (cmp_mmcm_rst)
			begin
				model_phase = '0;
				done_delay  = 0;
				lock_wait   = LOCK_CYCLES;
			end
			else
			begin
				if (lock_wait > 0)
					lock_wait--;
				if (cmp_psen)
				begin
					assert (cmp_psincdec ? (cmp_phase > model_phase) : (cmp_phase < model_phase))
					else
						report_error($sformatf("step from %0d away from target %0d",
							model_phase, cmp_phase));
					model_phase = cmp_psincdec ? model_phase + 1'b1 : model_phase - 1'b1;
					// psdone 2 to 12 cycles later
					done_delay = 2 + ($unsigned($random(seed)) % 11);
				end
				else if (done_delay > 0)
				begin
					done_delay--;
					done_fire = (done_delay == 0);
				end
			end
			#1;
			cmp_psdone = done_fire;
			cmp_locked = (lock_wait == 0);
		end
	end

	// ----------------------------------------
	// Comparator stimulus
	// ----------------------------------------
	task automatic request_phase(input int idx);
		cmp_phase_t expected;
		expected      = rule_phase(idx);
		cmp_clk_phase = cmp_phase_idx_t'(idx);
		@(posedge CLK40);
		#1;
		assert (cmp_phase == expected)
		else
			report_error($sformatf("cmp_phase %0d for index %0d, expected %0d",
				cmp_phase, idx, expected));
		#1;
	endtask

	// Walk ends with FSM idle and no change pending
	task automatic wait_walk_done(input int idx);
		int cycles;
		cycles = 0;
		repeat (4) @(posedge CLK40);
		#1;
		while (cmp_phs_change || cmp_phs_status.busy)
		begin
			cycles++;
			if (cycles > WALK_LIMIT)
			begin
				$display("Phase walk to index %0d did not finish in %0d cycles", idx, WALK_LIMIT);
				stop_with_failure();
			end
			@(posedge CLK40);
			#1;
		end
		assert (model_phase == cmp_phase)
		else
			report_error($sformatf("phase %0d after walk to index %0d, target %0d",
				model_phase, idx, cmp_phase));
		#1;
	endtask

	task automatic pulse_jtag_reset(input int cycles);
		cmp_phs_jtag_rst = 1'b1;
		repeat (cycles) @(posedge CLK40);
		#2;
		cmp_phs_jtag_rst = 1'b0;
	endtask

	task automatic run_phase_walks();
		int idx;
		request_phase(0);
		wait_walk_done(0);
		// Full period in one walk
		request_phase(31);
		wait_walk_done(31);
		repeat (6)
		begin
			idx = $unsigned($random(seed)) % `CMP_TABLE_SIZE;
			request_phase(idx);
			wait_walk_done(idx);
		end
		// JTAG reset in the middle of a walk restarts from zero
		request_phase(20);
		repeat (200) @(posedge CLK40);
		#2;
		pulse_jtag_reset(3);
		wait_walk_done(20);
		// Reset while settled and a fresh walk after it
		pulse_jtag_reset(2);
		request_phase(9);
		wait_walk_done(9);
	endtask

	// ----------------------------------------
	// Sampling side stimulus
	// ----------------------------------------
	task automatic wait_holdoff_end();
		int cycles;
		cycles = 0;
		@(posedge CLK40);
		#1;
		while (samp_ctrl.dsr_resync)
		begin
			cycles++;
			if (cycles > HOLDOFF_CYC + 100)
			begin
				$display("dsr_resync holdoff did not end in %0d cycles", HOLDOFF_CYC + 100);
				stop_with_failure();
			end
			@(posedge CLK40);
			#1;
		end
		#1;
	endtask

	task automatic strobe_phase_change();
		samp_clk_phase    = 3'($random(seed));
		samp_clk_phs_chng = 1'b1;
		@(posedge CLK40);
		#2;
		samp_clk_phs_chng = 1'b0;
	endtask

	task automatic run_resync_tests();
		// Holdoff from end of RST with random phase bits meanwhile
		repeat (1500)
		begin
			@(posedge CLK40);
			#2;
			samp_clk_phase = 3'($random(seed));
		end
		// Capture in mid holdoff must not extend it
		strobe_phase_change();
		wait_holdoff_end();
		repeat (20) @(posedge CLK40);
		#2;
		resync = 1'b1;
		repeat (5) @(posedge CLK40);
		#2;
		resync = 1'b0;
		wait_holdoff_end();
		repeat (8)
		begin
			strobe_phase_change();
			repeat (12) @(posedge CLK40);
			#2;
		end
		wait_holdoff_end();
	endtask

	// ----------------------------------------
	// Main sequence, watchdog, verdict
	// ----------------------------------------
	initial
	begin
		RST               = 1'b1;
		cmp_phs_jtag_rst  = 1'b0;
		cmp_clk_phase     = '0;
		resync            = 1'b0;
		samp_clk_phase    = '0;
		samp_clk_phs_chng = 1'b0;
		repeat (5) @(posedge CLK40);
		#2;
		RST = 1'b0;
		fork
			run_phase_walks();
			run_resync_tests();
		join
		repeat (10) @(posedge CLK40);
		if (DUT.u_assert.fail_count != 0)
			stop_with_failure();
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

	// Concurrent assertion failures end the run at once
	initial
	begin
		forever
		begin
			@(negedge CLK40);
			if (DUT.u_assert.fail_count != 0)
			begin
				$display("A concurrent assertion failed, see the message above");
				stop_with_failure();
			end
		end
	end

	initial
	begin
		repeat (RUN_LIMIT) @(posedge CLK40);
		$display("Watchdog expired after %0d cycles, the run did not finish", RUN_LIMIT);
		stop_with_failure();
	end

endmodule

// File: compile.f
+incdir+verilog
verilog/cmp_phase_pkg.sv
verilog/resync_pkg.sv
verilog/cmp_phase_cfg.sv
verilog/cmp_phase_tracker.sv
verilog/dyn_phase_shift_fsm.sv
verilog/resync_phase_ctrl.sv
verilog/dsr_holdoff.sv
verilog/clock_phase_ctrl.sv
tests/clock_phase_ctrl_assert.sv
tests/tb_clock_phase_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the clock phase control testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_clock_phase_ctrl
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -Mdir "$OBJ" -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation PASSED"
exit 0
